// ==== sim.f ====
+incdir+include
src/glueTypesPkg.sv
src/stageReg.sv
src/addressDecode.sv
src/accessTimer.sv
src/busGlue.sv
tb/clockGen.sv
tb/busGlueTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the busGlue testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module busGlueTb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output="$(./obj_dir/VbusGlueTb)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "PASS: all tests"; then
    exit 0
else
    exit 1
fi

// ==== tb/busGlueTb.sv ====
`timescale 1ns/1ps

`include "spaceMap.svh"

module busGlueTb;

    // Default wait parameters of busGlue
    localparam int romBaseWaitTb = 2;
    localparam int ciaWaitTb     = 6;
    localparam int rtcWaitTb     = 4;
    localparam int flashWaitTb   = 3;
    localparam int otherWaitTb   = 1;

    // Three accesses in flight at the slowest wait and doubled for stalls
    localparam int totalReq  = 130;
    localparam int timeoutNs = (totalReq * 3 * (ciaWaitTb + 3) * 2 + 200) * 20;

    logic                             CLK40;
    logic                             RESETn;
    logic [1:0]                       romDelay;
    logic                             reqValid;
    logic                             reqReady;
    glueTypesPkg::busRequest          req;
    logic [glueTypesPkg::csWidth-1:0] chipSel;
    logic                             rspValid;
    logic                             rspReady;
    glueTypesPkg::busResponse         rsp;

    logic [15:0] lfsr = 16'd45219;
    int          errors = 0;
    int          testsPassed = 0;
    int          testsFailed = 0;
    string       curTest = "reset";
    int          stallMode = 0;
    bit          timingOn = 0;
    int          rspIndex = 0;

    // Model state owned by the monitor
    glueTypesPkg::busRequest          pendReq[$];
    logic [1:0]                       pendDelay[$];
    int                               pendCycle[$];
    int                               cycle = 0;
    logic [glueTypesPkg::csWidth-1:0] selSeen = '0;
    int                               selCount = 0;
    bit                               rspOpen = 0;
    int                               rspStart = 0;
    int                               prevStart = 0;
    glueTypesPkg::busRequest          curReq;
    glueTypesPkg::decodedAccess       expAcc;
    glueTypesPkg::busResponse         expRsp;
    logic [1:0]                       curDelay;
    int                               curAccept;
    logic                             nextReady;

    clockGen u_clk (
        .CLK40  (CLK40),
        .RESETn (RESETn)
    );

    busGlue u_dut (
        .CLK40    (CLK40),
        .RESETn   (RESETn),
        .romDelay (romDelay),
        .reqValid (reqValid),
        .reqReady (reqReady),
        .req      (req),
        .chipSel  (chipSel),
        .rspValid (rspValid),
        .rspReady (rspReady),
        .rsp      (rsp)
    );

    //////////////////////////////
    // Random source and model
    //////////////////////////////

    // Galois LFSR stepped once per bit taken
    function automatic logic [19:0] randBits(input int n);
        logic [19:0] v;
        logic        b;
        v = '0;
        for (int i = 0; i < n; i++) begin
            b = lfsr[0];
            lfsr = lfsr >> 1;
            if (b) begin
                lfsr = lfsr ^ 16'hB400;
            end
            v = {v[18:0], b};
        end
        return v;
    endfunction

    // Expected decode from the address map rules
    function automatic glueTypesPkg::decodedAccess expectAccess(
        input glueTypesPkg::busRequest r
    );
        glueTypesPkg::decodedAccess d;
        glueTypesPkg::busSpace      s;
        s = glueTypesPkg::unmapped;
        if (r.addr <= `chipRamLimit) begin
            s = (r.ovl && r.addr <= `ovlRomLimit) ? glueTypesPkg::romSpace
                                                 : glueTypesPkg::chipRam;
        end else if (r.addr >= `romBase && r.addr <= `romLimit) begin
            s = glueTypesPkg::romSpace;
        end else if (r.addr >= `ciaBase && r.addr <= `ciaLimit) begin
            s = glueTypesPkg::ciaSpace;
        end else if (r.addr >= `rtcBase && r.addr <= `rtcLimit) begin
            s = glueTypesPkg::rtcSpace;
        end else if (r.addr == `regBase) begin
            s = glueTypesPkg::regSpace;
        end else if (r.addr >= `ataBase && r.addr <= `ataLimit) begin
            s = glueTypesPkg::ataSpace;
        end else if (r.addr >= `flashBase && r.addr <= `flashLimit) begin
            s = glueTypesPkg::flashSpace;
        end
        // Bursts only to wide memory
        if (r.tt != 2'b00 && s != glueTypesPkg::chipRam && s != glueTypesPkg::romSpace) begin
            s = glueTypesPkg::unmapped;
        end
        d = '0;
        d.space = s;
        d.rnw = r.rnw;
        case (s)
            glueTypesPkg::romSpace:   d.chipSel = 6'b000001;
            glueTypesPkg::ciaSpace:   d.chipSel = 6'b000010;
            glueTypesPkg::rtcSpace:   d.chipSel = 6'b000100;
            glueTypesPkg::regSpace:   d.chipSel = 6'b001000;
            glueTypesPkg::ataSpace:   d.chipSel = 6'b010000;
            glueTypesPkg::flashSpace: d.chipSel = 6'b100000;
            default:                  d.chipSel = 6'b000000;
        endcase
        // Every select but ROM is a narrow port
        d.narrowPort = (d.chipSel[5:1] != 5'b00000);
        // Registers, ATA and flash sit behind the shifters
        d.levelShift = (d.chipSel[5:3] != 3'b000);
        return d;
    endfunction

    function automatic int expectWait(input glueTypesPkg::busSpace s, input logic [1:0] dly);
        case (s)
            glueTypesPkg::romSpace:   return romBaseWaitTb + int'(dly);
            glueTypesPkg::ciaSpace:   return ciaWaitTb;
            glueTypesPkg::rtcSpace:   return rtcWaitTb;
            glueTypesPkg::flashSpace: return flashWaitTb;
            default:                  return otherWaitTb;
        endcase
    endfunction

    // Biased toward mapped windows with the last choice fully random
    function automatic glueTypesPkg::busRequest randomReq(input bit narrowBurst);
        glueTypesPkg::busRequest r;
        logic [19:0]             t;
        logic [19:0]             choice;
        choice = narrowBurst ? 20'd2 + (randBits(3) % 20'd5) : randBits(3);
        t = randBits(9);
        case (choice)
            20'd0:   r.addr = t;
            20'd1:   r.addr = `romBase + (t & 20'h0007F);
            20'd2:   r.addr = `ciaBase + (t & 20'h0000F);
            20'd3:   r.addr = `rtcBase + (t & 20'h0000F);
            20'd4:   r.addr = `regBase;
            20'd5:   r.addr = `ataBase + (t & 20'h0000F);
            20'd6:   r.addr = `flashBase + (t & 20'h0007F);
            default: r.addr = randBits(20);
        endcase
        t = randBits(4);
        r.rnw = t[0];
        r.ovl = t[1];
        r.tt  = t[3:2];
        if (narrowBurst && r.tt == 2'b00) begin
            r.tt = 2'b10;
        end
        return r;
    endfunction

    //////////////////////////////
    // Compare tasks
    //////////////////////////////

    task automatic checkResponse(input glueTypesPkg::busResponse expv,
                                 input glueTypesPkg::busResponse actv);
        if (expv !== actv) begin
            $display("[FAIL] %s response: expected %h actual %h", curTest, expv, actv);
            errors++;
        end
    endtask

    task automatic checkChipSel(input logic [glueTypesPkg::csWidth-1:0] expv,
                                input logic [glueTypesPkg::csWidth-1:0] actv);
        if (expv !== actv) begin
            $display("[FAIL] %s chip select: expected %b actual %b", curTest, expv, actv);
            errors++;
        end
    endtask

    task automatic checkCount(input string what, input int expv, input int actv);
        if (expv != actv) begin
            $display("[FAIL] %s %s: expected %0d actual %0d", curTest, what, expv, actv);
            errors++;
        end
    endtask

    //////////////////////////////
    // Monitor at the falling edge
    //////////////////////////////

    always @(negedge CLK40) begin
        cycle = cycle + 1;
        if (RESETn) begin
            // Ready low means both registers and the timer are busy
            if (!reqReady && pendReq.size() != 3) begin
                $display("%s: request ready dropped with %0d accesses in flight",
                         curTest, pendReq.size());
                errors++;
            end
            if (reqValid && reqReady) begin
                pendReq.push_back(req);
                pendDelay.push_back(romDelay);
                pendCycle.push_back(cycle);
            end
            // Count select cycles of the access in the timer
            if (chipSel != '0) begin
                if (selCount != 0 && chipSel != selSeen) begin
                    $display("%s: chip select changed during one access", curTest);
                    errors++;
                end
                selSeen = chipSel;
                selCount++;
            end
            if (rspValid && !rspOpen) begin
                rspOpen = 1;
                rspStart = cycle;
            end
            // Oldest request pairs with this response
            if (rspValid && rspReady) begin
                if (pendReq.size() == 0) begin
                    $display("%s: response arrived with no request outstanding", curTest);
                    errors++;
                end else begin
                    curReq = pendReq.pop_front();
                    curDelay = pendDelay.pop_front();
                    curAccept = pendCycle.pop_front();
                    expAcc = expectAccess(curReq);
                    expRsp.space = expAcc.space;
                    expRsp.narrowPort = expAcc.narrowPort;
                    expRsp.levelShift = expAcc.levelShift;
                    expRsp.error = (expAcc.space == glueTypesPkg::unmapped);
                    checkResponse(expRsp, rsp);
                    checkChipSel(expAcc.chipSel, (selCount != 0) ? selSeen : '0);
                    checkCount("select cycles",
                               (expAcc.chipSel != '0) ? expectWait(expAcc.space, curDelay) : 0,
                               selCount);
                    if (timingOn) begin
                        // Sampled half a cycle before the accepting edge
                        if (rspIndex == 0) begin
                            checkCount("latency", 2 + otherWaitTb, rspStart - curAccept - 1);
                        end else begin
                            checkCount("response spacing", otherWaitTb + 1, rspStart - prevStart);
                        end
                        prevStart = rspStart;
                        rspIndex++;
                    end
                end
                selCount = 0;
                selSeen = '0;
                rspOpen = 0;
            end
        end
    end

    // Stall pattern chosen at the falling edge and applied after the rising edge
    always begin
        @(negedge CLK40);
        case (stallMode)
            1:       nextReady = (randBits(2) != 20'd0);
            2:       nextReady = randBits(1) != 20'd0;
            default: nextReady = 1'b1;
        endcase
        @(posedge CLK40);
        #1 rspReady = nextReady;
    end

    //////////////////////////////
    // Driver and test sequence
    //////////////////////////////

    // Hold the request until the register takes it
    task automatic sendReq(input glueTypesPkg::busRequest r);
        logic ok;
        reqValid = 1'b1;
        req = r;
        ok = 1'b0;
        while (!ok) begin
            @(negedge CLK40);
            ok = reqReady;
            @(posedge CLK40);
            #1;
        end
        reqValid = 1'b0;
    endtask

    task automatic runTest(input string name, input int count, input int stalls,
                           input bit gaps, input bit narrowBurst, input bit timed);
        glueTypesPkg::busRequest r;
        int                      errBefore;
        int                      idle;
        errBefore = errors;
        curTest = name;
        romDelay = 2'(randBits(2));
        stallMode = stalls;
        rspIndex = 0;
        timingOn = timed;
        for (int i = 0; i < count; i++) begin
            // Timed runs use plain chip RAM reads
            if (timed) begin
                r = '0;
                r.addr = randBits(9) | 20'h00100;
            end else begin
                r = randomReq(narrowBurst);
            end
            sendReq(r);
            if (gaps) begin
                idle = int'(randBits(2));
                repeat (idle) begin
                    @(posedge CLK40);
                    #1;
                end
            end
        end
        // Drain before the next test
        while (pendReq.size() != 0) begin
            @(posedge CLK40);
            #1;
        end
        stallMode = 0;
        timingOn = 0;
        if (errors == errBefore) begin
            testsPassed++;
            $display("test %s: ok", name);
        end else begin
            testsFailed++;
            $display("test %s: failed with %0d errors", name, errors - errBefore);
        end
    endtask

    initial begin
        romDelay = 2'b00;
        reqValid = 1'b0;
        req = '0;
        rspReady = 1'b1;
        while (RESETn !== 1'b1) begin
            @(posedge CLK40);
        end
        @(negedge CLK40);
        if (rspValid !== 1'b0 || chipSel !== '0 || reqReady !== 1'b1) begin
            $display("reset: outputs not idle after reset");
            errors++;
            testsFailed++;
        end else begin
            testsPassed++;
        end
        $display("test reset: %s", (errors == 0) ? "ok" : "failed");
        @(posedge CLK40);
        #1;
        runTest("decode", 60, 1, 1'b1, 1'b0, 1'b0);
        runTest("burstRule", 20, 0, 1'b0, 1'b1, 1'b0);
        runTest("backPressure", 40, 2, 1'b0, 1'b0, 1'b0);
        runTest("throughput", 10, 0, 1'b0, 1'b0, 1'b1);
        $display("tests passed %0d failed %0d", testsPassed, testsFailed);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(timeoutNs);
        $display("Run timed out in test %s, a response never arrived", curTest);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== tb/clockGen.sv ====
`timescale 1ns/1ps

module clockGen (
    output logic CLK40,
    output logic RESETn
);

    // 20 ns period
    initial begin
        CLK40 = 1'b0;
        forever #10 CLK40 = ~CLK40;
    end

    // Reset held low for 8 rising edges
    initial begin
        RESETn = 1'b0;
        repeat (8) @(posedge CLK40);
        #1 RESETn = 1'b1;
    end

endmodule

// ==== src/busGlue.sv ====
`timescale 1ns/1ps

module busGlue #(
    parameter logic [3:0] romBaseWait = 4'd2,
    parameter logic [3:0] ciaWait     = 4'd6,
    parameter logic [3:0] rtcWait     = 4'd4,
    parameter logic [3:0] flashWait   = 4'd3,
    parameter logic [3:0] otherWait   = 4'd1
) (
    input  logic                              CLK40,
    input  logic                              RESETn,
    input  logic [1:0]                        romDelay,
    input  logic                              reqValid,
    output logic                              reqReady,
    input  glueTypesPkg::busRequest           req,
    output logic [glueTypesPkg::csWidth-1:0]  chipSel,
    output logic                              rspValid,
    input  logic                              rspReady,
    output glueTypesPkg::busResponse          rsp
);

    // Request register to decoder
    logic                       reqQValid;
    logic                       reqQReady;
    glueTypesPkg::busRequest    reqQ;

    // Decode register to timer
    logic                       decValid;
    logic                       decReady;
    glueTypesPkg::decodedAccess decAcc;

    //////////////////////////////
    // Stage 1 request register
    //////////////////////////////

    stageReg #(
        .payloadT (glueTypesPkg::busRequest)
    ) u_reqStage (
        .CLK40    (CLK40),
        .RESETn   (RESETn),
        .inValid  (reqValid),
        .inReady  (reqReady),
        .inData   (req),
        .outValid (reqQValid),
        .outReady (reqQReady),
        .outData  (reqQ)
    );

    // Stage 2 decode with its own output register
    addressDecode u_decode (
        .CLK40    (CLK40),
        .RESETn   (RESETn),
        .inValid  (reqQValid),
        .inReady  (reqQReady),
        .inReq    (reqQ),
        .outValid (decValid),
        .outReady (decReady),
        .outAcc   (decAcc)
    );

    //////////////////////////////
    // Stage 3 wait states
    //////////////////////////////

    accessTimer #(
        .romBaseWait (romBaseWait),
        .ciaWait     (ciaWait),
        .rtcWait     (rtcWait),
        .flashWait   (flashWait),
        .otherWait   (otherWait)
    ) u_timer (
        .CLK40    (CLK40),
        .RESETn   (RESETn),
        .romDelay (romDelay),
        .inValid  (decValid),
        .inReady  (decReady),
        .inAcc    (decAcc),
        .chipSel  (chipSel),
        .rspValid (rspValid),
        .rspReady (rspReady),
        .rsp      (rsp)
    );

endmodule

// ==== src/accessTimer.sv ====
`timescale 1ns/1ps

module accessTimer #(
    parameter logic [3:0] romBaseWait = 4'd2,
    parameter logic [3:0] ciaWait     = 4'd6,
    parameter logic [3:0] rtcWait     = 4'd4,
    parameter logic [3:0] flashWait   = 4'd3,
    parameter logic [3:0] otherWait   = 4'd1
) (
    input  logic                              CLK40,
    input  logic                              RESETn,
    input  logic [1:0]                        romDelay,
    input  logic                              inValid,
    output logic                              inReady,
    input  glueTypesPkg::decodedAccess        inAcc,
    output logic [glueTypesPkg::csWidth-1:0]  chipSel,
    output logic                              rspValid,
    input  logic                              rspReady,
    output glueTypesPkg::busResponse          rsp
);

    typedef enum logic [1:0] {
        stIdle = 2'd0,
        stWait = 2'd1,
        stRsp  = 2'd2
    } timerState;

    timerState                         state;
    logic                              accept;
    logic [4:0]                        waitLoad;
    logic [4:0]                        waitCnt;
    logic [glueTypesPkg::csWidth-1:0]  csHold;
    glueTypesPkg::busResponse          rspHold;

    // Take a new access when idle or as the response leaves
    assign inReady = (state == stIdle) || ((state == stRsp) && rspReady);
    assign accept  = inValid && inReady;

    //////////////////////////////
    // Wait count per space
    //////////////////////////////

    always_comb begin
        case (inAcc.space)
            // ROM delay jumper adds up to three states
            glueTypesPkg::romSpace:   waitLoad = {1'b0, romBaseWait} + {3'b000, romDelay};
            // Fixed count stands in for the E-clock phase
            glueTypesPkg::ciaSpace:   waitLoad = {1'b0, ciaWait};
            glueTypesPkg::rtcSpace:   waitLoad = {1'b0, rtcWait};
            glueTypesPkg::flashSpace: waitLoad = {1'b0, flashWait};
            default:                  waitLoad = {1'b0, otherWait};
        endcase
    end

    //////////////////////////////
    // Cycle FSM
    //////////////////////////////

    always_ff @(posedge CLK40) begin
        if (!RESETn) begin
            state   <= stIdle;
            waitCnt <= '0;
        end else if (accept) begin
            state   <= stWait;
            waitCnt <= waitLoad;
        end else begin
            case (state)
                stWait: begin
                    // Terminate after the last wait state
                    if (waitCnt <= 5'd1) begin
                        state <= stRsp;
                    end else begin
                        waitCnt <= waitCnt - 5'd1;
                    end
                end
                stRsp: begin
                    if (rspReady) begin
                        state <= stIdle;
                    end
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    // Access details captured at acceptance
    always_ff @(posedge CLK40) begin
        if (accept) begin
            csHold             <= inAcc.chipSel;
            rspHold.space      <= inAcc.space;
            rspHold.narrowPort <= inAcc.narrowPort;
            rspHold.levelShift <= inAcc.levelShift;
            rspHold.error      <= (inAcc.space == glueTypesPkg::unmapped);
        end
    end

    // Select only during wait states
    assign chipSel  = (state == stWait) ? csHold : '0;
    assign rspValid = (state == stRsp);
    assign rsp      = rspHold;

    //////////////////////////////
    // Checks
    //////////////////////////////

    property noSelInRsp;
        @(posedge CLK40) disable iff (!RESETn)
        rspValid |-> (chipSel == '0);
    endproperty

    assertNoSel : assert property (noSelInRsp)
        else $error("chip select active during termination");

endmodule

// ==== src/addressDecode.sv ====
`timescale 1ns/1ps

`include "spaceMap.svh"

module addressDecode (
    input  logic                       CLK40,
    input  logic                       RESETn,
    input  logic                       inValid,
    output logic                       inReady,
    input  glueTypesPkg::busRequest    inReq,
    output logic                       outValid,
    input  logic                       outReady,
    output glueTypesPkg::decodedAccess outAcc
);

    glueTypesPkg::busSpace      mapSpace;
    glueTypesPkg::busSpace      finalSpace;
    glueTypesPkg::decodedAccess decAcc;

    // Addresses below the base wrap to a large offset
    function automatic logic inRange(
        input logic [19:0] a,
        input logic [19:0] lo,
        input logic [19:0] hi
    );
        logic [19:0] offset;
        offset = a - lo;
        return offset <= (hi - lo);
    endfunction

    //////////////////////////////
    // Address compare
    //////////////////////////////

    // Anything with A[31:24] set misses every window below
    always_comb begin
        if (inRange(inReq.addr, `chipRamBase, `chipRamLimit)) begin
            // Overlay maps ROM at zero after reset
            if (inReq.ovl && inRange(inReq.addr, `chipRamBase, `ovlRomLimit)) begin
                mapSpace = glueTypesPkg::romSpace;
            end else begin
                mapSpace = glueTypesPkg::chipRam;
            end
        end else if (inRange(inReq.addr, `romBase, `romLimit)) begin
            mapSpace = glueTypesPkg::romSpace;
        end else if (inRange(inReq.addr, `ciaBase, `ciaLimit)) begin
            mapSpace = glueTypesPkg::ciaSpace;
        end else if (inRange(inReq.addr, `rtcBase, `rtcLimit)) begin
            mapSpace = glueTypesPkg::rtcSpace;
        end else if (inRange(inReq.addr, `regBase, `regLimit)) begin
            mapSpace = glueTypesPkg::regSpace;
        end else if (inRange(inReq.addr, `ataBase, `ataLimit)) begin
            mapSpace = glueTypesPkg::ataSpace;
        end else if (inRange(inReq.addr, `flashBase, `flashLimit)) begin
            mapSpace = glueTypesPkg::flashSpace;
        end else begin
            mapSpace = glueTypesPkg::unmapped;
        end
    end

    // Narrow ports cannot take line or move16 bursts
    always_comb begin
        finalSpace = mapSpace;
        if ((inReq.tt != 2'b00) &&
            (mapSpace != glueTypesPkg::chipRam) &&
            (mapSpace != glueTypesPkg::romSpace)) begin
            finalSpace = glueTypesPkg::unmapped;
        end
    end

    //////////////////////////////
    // Select and port flags
    //////////////////////////////

    always_comb begin
        decAcc            = '0;
        decAcc.space      = finalSpace;
        decAcc.rnw        = inReq.rnw;
        case (finalSpace)
            glueTypesPkg::romSpace: begin
                decAcc.chipSel[glueTypesPkg::csRom] = 1'b1;
            end
            glueTypesPkg::ciaSpace: begin
                decAcc.chipSel[glueTypesPkg::csCia] = 1'b1;
                decAcc.narrowPort = 1'b1;
            end
            glueTypesPkg::rtcSpace: begin
                decAcc.chipSel[glueTypesPkg::csRtc] = 1'b1;
                decAcc.narrowPort = 1'b1;
            end
            // LVTTL side sits behind the level shifters
            glueTypesPkg::regSpace: begin
                decAcc.chipSel[glueTypesPkg::csReg] = 1'b1;
                decAcc.narrowPort = 1'b1;
                decAcc.levelShift = 1'b1;
            end
            glueTypesPkg::ataSpace: begin
                decAcc.chipSel[glueTypesPkg::csAta] = 1'b1;
                decAcc.narrowPort = 1'b1;
                decAcc.levelShift = 1'b1;
            end
            glueTypesPkg::flashSpace: begin
                decAcc.chipSel[glueTypesPkg::csFlash] = 1'b1;
                decAcc.narrowPort = 1'b1;
                decAcc.levelShift = 1'b1;
            end
            // Chip RAM is decoded by the RAM controller
            default: begin
                decAcc.chipSel = '0;
            end
        endcase
    end

    // Output register of the decode stage
    stageReg #(
        .payloadT (glueTypesPkg::decodedAccess)
    ) u_decStage (
        .CLK40    (CLK40),
        .RESETn   (RESETn),
        .inValid  (inValid),
        .inReady  (inReady),
        .inData   (decAcc),
        .outValid (outValid),
        .outReady (outReady),
        .outData  (outAcc)
    );

    // Registered select is zero or one-hot
    property selOneHot;
        @(posedge CLK40) disable iff (!RESETn)
        outValid |-> $onehot0(outAcc.chipSel);
    endproperty

    assertSel : assert property (selOneHot)
        else $error("decoded chip select not zero or one-hot");

endmodule

// ==== src/stageReg.sv ====
`timescale 1ns/1ps

module stageReg #(
    parameter type payloadT = logic
) (
    input  logic    CLK40,
    input  logic    RESETn,
    input  logic    inValid,
    output logic    inReady,
    input  payloadT inData,
    output logic    outValid,
    input  logic    outReady,
    output payloadT outData
);

    logic inXfer;

    // Free slot, or the held entry leaves this same edge
    assign inReady = !outValid || outReady;
    assign inXfer  = inValid && inReady;

    //////////////////////////////
    // Valid flag
    //////////////////////////////

    always_ff @(posedge CLK40) begin
        if (!RESETn) begin
            outValid <= 1'b0;
        end else if (inXfer) begin
            outValid <= 1'b1;
        end else if (outReady) begin
            // Entry drained with nothing behind it
            outValid <= 1'b0;
        end
    end

    // Payload only moves on an accepted transfer
    always_ff @(posedge CLK40) begin
        if (inXfer) begin
            outData <= inData;
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    // Stalled output keeps both valid and payload
    property holdWhileStalled;
        @(posedge CLK40) disable iff (!RESETn)
        (outValid && !outReady) |=> (outValid && $stable(outData));
    endproperty

    assertHold : assert property (holdWhileStalled)
        else $error("stageReg output changed while stalled");

endmodule

// ==== src/glueTypesPkg.sv ====
package glueTypesPkg;

    //////////////////////////////
    // Address spaces
    //////////////////////////////

    // Spaces seen by the local-bus decoder
    typedef enum logic [2:0] {
        chipRam    = 3'd0,
        romSpace   = 3'd1,
        ciaSpace   = 3'd2,
        rtcSpace   = 3'd3,
        regSpace   = 3'd4,
        ataSpace   = 3'd5,
        flashSpace = 3'd6,
        unmapped   = 3'd7
    } busSpace;

    // Chip select lines, chip RAM has none
    localparam int csWidth = 6;

    // Bit positions inside the chip select vector
    localparam int csRom   = 0;
    localparam int csCia   = 1;
    localparam int csRtc   = 2;
    localparam int csReg   = 3;
    localparam int csAta   = 4;
    localparam int csFlash = 5;

    //////////////////////////////
    // Pipeline payloads
    //////////////////////////////

    // Cycle request as sampled at transfer start
    typedef struct packed {
        logic [19:0] addr;   // A[31:12]
        logic        rnw;
        logic [1:0]  tt;     // Transfer type
        logic        ovl;    // ROM overlay active
    } busRequest;

    // Result of the decode stage
    typedef struct packed {
        busSpace              space;
        logic [csWidth-1:0]   chipSel;     // One-hot or zero
        logic                 narrowPort;
        logic                 levelShift;
        logic                 rnw;
    } decodedAccess;

    // Termination response back to the CPU side
    typedef struct packed {
        busSpace space;
        logic    narrowPort;
        logic    levelShift;
        logic    error;      // Unmapped or illegal burst
    } busResponse;

endpackage

// ==== include/spaceMap.svh ====
`ifndef spaceMapSvh
`define spaceMapSvh

//////////////////////////////
// Address map on A[31:12]
//////////////////////////////

// Motherboard chip RAM, 2 MB
`define chipRamBase   20'h00000
`define chipRamLimit  20'h001FF

// Low chip RAM shadowed by ROM while OVL is set
`define ovlRomLimit   20'h0007F

// Flash, 512 KB
`define flashBase     20'h00A00
`define flashLimit    20'h00A7F

// Both CIAs share the BFxxxx block
`define ciaBase       20'h00BF0
`define ciaLimit      20'h00BFF

// ATA controller
`define ataBase       20'h00DA0
`define ataLimit      20'h00DAF

// Real time clock
`define rtcBase       20'h00DC0
`define rtcLimit      20'h00DCF

// Custom chip registers, a single 4 KB page
`define regBase       20'h00DFF
`define regLimit      20'h00DFF

// Kickstart ROM, 512 KB
`define romBase       20'h00F80
`define romLimit      20'h00FFF

`endif
